// ==== build.f ====
+incdir+tb
src/tetris_pkg.sv
src/piece_rotate.sv
src/piece_fit.sv
src/falling_piece.sv
src/settled_field.sv
src/cell_query.sv
src/tetris_core.sv
tb/tb_tetris_core.sv

// ==== Bender.yml ====
package:
  name: tetris_core

sources:
  - src/tetris_pkg.sv
  - src/piece_rotate.sv
  - src/piece_fit.sv
  - src/falling_piece.sv
  - src/settled_field.sv
  - src/cell_query.sv
  - src/tetris_core.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/tb_tetris_core.sv

// ==== tb/tetris_checks.svh ====
`ifndef TETRIS_CHECKS_SVH
`define TETRIS_CHECKS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reference model state.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

tetris_pkg::piece_t m_piece;
tetris_pkg::field_t m_field;
logic               m_active;
logic               m_lock;
int                 m_lines;

localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
logic [31:0]            lfsr_state = 32'hd010;

function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic [31:0] n;

    n = s >> 1;
    if (s[0])
        n = n ^ LFSR_TAPS;
    return n;
endfunction

// One LFSR step per bit taken.
function automatic logic [31:0] random_bits(input int n);
    logic [31:0] v;

    v = '0;
    for (int i = 0; i < n; i++)
    begin
        lfsr_state = lfsr_step(lfsr_state);
        v = {v[30:0], lfsr_state[0]};
    end
    return v;
endfunction

// New (r,c) takes old (3-c, r).
function automatic tetris_pkg::shape_t rotate_cw(input tetris_pkg::shape_t s);
    tetris_pkg::shape_t res;

    for (int r = 0; r < 4; r++)
        for (int c = 0; c < 4; c++)
            res[r*4 + c] = s[(3-c)*4 + r];
    return res;
endfunction

// New (r,c) takes old (c, 3-r).
function automatic tetris_pkg::shape_t rotate_ccw(input tetris_pkg::shape_t s);
    tetris_pkg::shape_t res;

    for (int r = 0; r < 4; r++)
        for (int c = 0; c < 4; c++)
            res[r*4 + c] = s[c*4 + (3-r)];
    return res;
endfunction

function automatic logic shape_fits(input tetris_pkg::shape_t shape, input int col,
                                    input int row, input tetris_pkg::field_t f);
    int gr;
    int gc;

    for (int r = 0; r < 4; r++)
    begin
        for (int c = 0; c < 4; c++)
        begin
            gr = row + r;
            gc = col + c;
            if (shape[r*4 + c])
            begin
                if (gc < 0 || gc >= tetris_pkg::GRID_COLS ||
                    gr < 0 || gr >= tetris_pkg::GRID_ROWS)
                    return 1'b0;
                if (f[gr*tetris_pkg::GRID_COLS + gc])
                    return 1'b0;
            end
        end
    end
    return 1'b1;
endfunction

function automatic tetris_pkg::field_t merge_piece(input tetris_pkg::field_t f,
                                                   input tetris_pkg::piece_t p);
    tetris_pkg::field_t res;
    int                 gr;
    int                 gc;

    res = f;
    for (int r = 0; r < 4; r++)
    begin
        for (int c = 0; c < 4; c++)
        begin
            gr = int'(p.row) + r;
            gc = int'($signed(p.col)) + c;
            if (p.shape[r*4 + c] && gc >= 0 && gc < tetris_pkg::GRID_COLS &&
                gr < tetris_pkg::GRID_ROWS)
                res[gr*tetris_pkg::GRID_COLS + gc] = 1'b1;
        end
    end
    return res;
endfunction

// Compacts the rows that are not full toward the bottom.
function automatic tetris_pkg::field_t clear_rows(input tetris_pkg::field_t f,
                                                  output int removed);
    tetris_pkg::field_t res;
    int                 dst;

    res = '0;
    dst = tetris_pkg::GRID_ROWS - 1;
    removed = 0;
    for (int r = tetris_pkg::GRID_ROWS - 1; r >= 0; r--)
    begin
        if (&f[r*tetris_pkg::GRID_COLS +: tetris_pkg::GRID_COLS])
            removed++;
        else
        begin
            res[dst*tetris_pkg::GRID_COLS +: tetris_pkg::GRID_COLS] =
                f[r*tetris_pkg::GRID_COLS +: tetris_pkg::GRID_COLS];
            dst--;
        end
    end
    return res;
endfunction

function automatic tetris_pkg::cell_e classify_cell(input tetris_pkg::piece_t p,
                                                    input logic active,
                                                    input tetris_pkg::field_t f,
                                                    input int qc, input int qr);
    int dr;
    int dc;

    if (active)
    begin
        dr = qr - int'(p.row);
        dc = qc - int'($signed(p.col));
        if (dr >= 0 && dr < 4 && dc >= 0 && dc < 4)
        begin
            if (p.shape[dr*4 + dc])
                return tetris_pkg::CELL_FALLING;
        end
    end
    if (qc >= 0 && qc < tetris_pkg::GRID_COLS && qr >= 0 && qr < tetris_pkg::GRID_ROWS)
    begin
        if (f[qr*tetris_pkg::GRID_COLS + qc])
            return tetris_pkg::CELL_SETTLED;
    end
    return tetris_pkg::CELL_EMPTY;
endfunction

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Protocol properties.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

a_cmd_needs_piece: assert property (@(posedge Clk) disable iff (rst)
    cmd_ready |-> piece_active)
else
begin
    protocol_errors++;
    $display("Fail at %0t: cmd_ready high with no active piece", $time);
end

a_cmd_one_cycle: assert property (@(posedge Clk) disable iff (rst)
    cmd_ready |=> !cmd_ready)
else
begin
    protocol_errors++;
    $display("Fail at %0t: cmd_ready held for more than one cycle", $time);
end

a_over_sticky: assert property (@(posedge Clk) disable iff (rst)
    game_over |=> game_over)
else
begin
    protocol_errors++;
    $display("Fail at %0t: game_over fell without reset", $time);
end

a_over_blocks_spawn: assert property (@(posedge Clk) disable iff (rst)
    game_over |-> !spawn_ready)
else
begin
    protocol_errors++;
    $display("Fail at %0t: spawn_ready high after game over", $time);
end

a_spawn_when_idle: assert property (@(posedge Clk) disable iff (rst)
    spawn_ready |-> !piece_active)
else
begin
    protocol_errors++;
    $display("Fail at %0t: spawn_ready high while a piece is active", $time);
end

a_falling_needs_piece: assert property (@(posedge Clk) disable iff (rst)
    (query_cell == tetris_pkg::CELL_FALLING) |-> piece_active)
else
begin
    protocol_errors++;
    $display("Fail at %0t: falling cell reported with no active piece", $time);
end

a_lines_step_by_one: assert property (@(posedge Clk) disable iff (rst)
    (lines_cleared != $past(lines_cleared)) |-> (lines_cleared == $past(lines_cleared) + 16'd1))
else
begin
    protocol_errors++;
    $display("Fail at %0t: lines_cleared jumped by more than one", $time);
end

`endif

// ==== tb/tb_tetris_core.sv ====
module tb_tetris_core;

    // 800 frame steps of 8 cycles, plus row clearing and margin.
    localparam int STEP_CYCLES  = 8;
    localparam int MAX_STEPS    = 800;
    localparam int CLEAR_CYCLES = 1600;
    localparam int CYCLE_LIMIT  = MAX_STEPS * STEP_CYCLES + CLEAR_CYCLES;

    localparam tetris_pkg::shape_t T_SHAPE = 16'h04E0;
    localparam tetris_pkg::shape_t H_BAR   = 16'h000F;
    localparam tetris_pkg::shape_t V_BAR   = 16'h1111;

    logic               Clk = 1'b0;
    logic               rst;
    logic               frame;
    tetris_pkg::spawn_t spawn;
    logic               spawn_valid;
    logic               spawn_ready;
    tetris_pkg::move_e  cmd;
    logic               cmd_valid;
    logic               cmd_ready;
    tetris_pkg::col_t   query_col;
    tetris_pkg::row_t   query_row;
    tetris_pkg::cell_e  query_cell;
    tetris_pkg::piece_t piece;
    logic               piece_active;
    tetris_pkg::field_t field;
    logic [15:0]        lines_cleared;
    logic               game_over;
    int                 value_errors = 0;
    int                 protocol_errors = 0;
    int                 cycles;

    always #5 Clk = ~Clk;

    tetris_core i_tetris_core (
        .Clk, .rst, .frame, .spawn, .spawn_valid, .spawn_ready, .cmd, .cmd_valid,
        .cmd_ready, .query_col, .query_row, .query_cell, .piece, .piece_active,
        .field, .lines_cleared, .game_over
    );

    `include "tetris_checks.svh"

    task automatic expect_true(input logic ok, input string what);
        assert (ok)
        else
        begin
            value_errors++;
            $display("Fail at %0t: %s", $time, what);
        end
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (2) @(posedge Clk);
        #1;
        rst = 1'b0;
        m_field  = '0;
        m_lines  = 0;
        m_active = 1'b0;
        m_lock   = 1'b0;
        expect_true(piece_active === 1'b0 && cmd_ready === 1'b0 && game_over === 1'b0,
                    "status flags not clear after reset");
        expect_true(spawn_ready === 1'b1, "spawn_ready low after reset");
        expect_true(field === '0 && lines_cleared === 16'd0,
                    "field or count not clear after reset");
    endtask

    // Query random cells while piece and field hold still.
    task automatic probe_cells(input int n);
        logic [31:0]       r;
        tetris_pkg::cell_e expected;

        for (int i = 0; i < n; i++)
        begin
            r = random_bits(11);
            query_col = tetris_pkg::col_t'(r[10:5]);
            query_row = tetris_pkg::row_t'(r[4:0]);
            @(posedge Clk);
            #1;
            expected = classify_cell(m_piece, m_active, m_field, int'($signed(query_col)),
                                     int'(query_row));
            expect_true(query_cell === expected,
                        $sformatf("cell (%0d,%0d) is %0d, expected %0d", $signed(query_col),
                                  query_row, query_cell, expected));
        end
    endtask

    task automatic spawn_piece(input tetris_pkg::shape_t shape, input tetris_pkg::color_t color);
        tetris_pkg::piece_t expected;
        logic               fits;

        fits = shape_fits(shape, int'(tetris_pkg::SPAWN_COL), int'(tetris_pkg::SPAWN_ROW),
                          m_field);
        spawn.shape = shape;
        spawn.color = color;
        spawn_valid = 1'b1;
        while (spawn_ready !== 1'b1)
        begin
            @(posedge Clk);
            #1;
        end
        @(posedge Clk);
        #1;
        spawn_valid = 1'b0;
        if (fits)
        begin
            expected.shape = shape;
            expected.col   = tetris_pkg::SPAWN_COL;
            expected.row   = tetris_pkg::SPAWN_ROW;
            expected.color = color;
            m_piece  = expected;
            m_active = 1'b1;
            m_lock   = 1'b0;
            expect_true(piece === expected && piece_active === 1'b1,
                        $sformatf("spawned piece %h, expected %h", piece, expected));
        end
        else
        begin
            expect_true(game_over === 1'b1 && spawn_ready === 1'b0 && piece_active === 1'b0,
                        "blocked spawn did not end the game");
        end
    endtask

    // One frame tick; the piece changes on the third edge after frame is seen.
    task automatic frame_step(input logic use_cmd, input tetris_pkg::move_e move);
        tetris_pkg::piece_t expected;
        logic               can_fall;
        int                 col;
        int                 row;

        col = int'($signed(m_piece.col));
        row = int'(m_piece.row);
        can_fall = shape_fits(m_piece.shape, col, row + 1, m_field);
        expected = m_piece;
        if (!can_fall)
            m_lock = 1'b1;
        else if (use_cmd)
        begin
            case (move)
                tetris_pkg::MOVE_LEFT:
                    if (shape_fits(m_piece.shape, col - 1, row, m_field))
                        expected.col = tetris_pkg::col_t'(col - 1);
                tetris_pkg::MOVE_RIGHT:
                    if (shape_fits(m_piece.shape, col + 1, row, m_field))
                        expected.col = tetris_pkg::col_t'(col + 1);
                tetris_pkg::ROT_CW:
                    if (shape_fits(rotate_cw(m_piece.shape), col, row, m_field))
                        expected.shape = rotate_cw(m_piece.shape);
                default:
                    if (shape_fits(rotate_ccw(m_piece.shape), col, row, m_field))
                        expected.shape = rotate_ccw(m_piece.shape);
            endcase
        end
        else
            expected.row = tetris_pkg::row_t'(row + 1);

        frame = 1'b1;
        cmd = move;
        cmd_valid = use_cmd && can_fall;
        @(posedge Clk);
        #1;
        expect_true(piece === m_piece, "piece changed one edge after frame");
        @(posedge Clk);
        #1;
        expect_true(piece === m_piece, "piece changed two edges after frame");
        expect_true(cmd_ready === can_fall,
                    $sformatf("cmd_ready is %b in the step cycle", cmd_ready));
        @(posedge Clk);
        #1;
        cmd_valid = 1'b0;
        expect_true(piece === expected,
                    $sformatf("piece %h after step, expected %h", piece, expected));
        expect_true(i_tetris_core.lock_valid === m_lock, "lock_valid wrong after step");
        m_piece = expected;
        @(posedge Clk);
        #1;
        frame = 1'b0;
        if (m_lock)
        begin
            repeat (4)
            begin
                @(posedge Clk);
                #1;
            end
        end
        else
            probe_cells(4);
    endtask

    task automatic finish_lock();
        int removed;

        while (spawn_ready !== 1'b1)
        begin
            @(posedge Clk);
            #1;
        end
        m_field  = merge_piece(m_field, m_piece);
        m_field  = clear_rows(m_field, removed);
        m_lines  = m_lines + removed;
        m_active = 1'b0;
        m_lock   = 1'b0;
        expect_true(i_tetris_core.lock_valid === 1'b0 && piece_active === 1'b0,
                    "piece still active after the lock");
        expect_true(field === m_field, $sformatf("field %h, expected %h", field, m_field));
        expect_true(lines_cleared === 16'(m_lines),
                    $sformatf("lines_cleared %0d, expected %0d", lines_cleared, m_lines));
        probe_cells(4);
    endtask

    task automatic run_piece(input tetris_pkg::shape_t shape, input tetris_pkg::color_t color,
                             input int lefts, input int rights, input logic random_cmds);
        logic [31:0] pick;
        int          steps;

        steps = 0;
        spawn_piece(shape, color);
        for (int i = 0; i < lefts; i++)
            frame_step(1'b1, tetris_pkg::MOVE_LEFT);
        for (int i = 0; i < rights; i++)
            frame_step(1'b1, tetris_pkg::MOVE_RIGHT);
        while (!m_lock)
        begin
            if (random_cmds && steps < 40)
            begin
                pick = random_bits(3);
                frame_step(pick[2], tetris_pkg::move_e'(pick[1:0]));
            end
            else
                frame_step(1'b0, tetris_pkg::MOVE_LEFT);
            steps++;
        end
        finish_lock();
    endtask

    task automatic hold_after_over();
        spawn_valid = 1'b1;
        repeat (16)
        begin
            @(posedge Clk);
            #1;
            expect_true(game_over === 1'b1 && spawn_ready === 1'b0, "game over did not hold");
        end
        spawn_valid = 1'b0;
    endtask

    initial
    begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT)
        begin
            @(posedge Clk);
            cycles++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
        $display("** FAIL **");
        $finish;
    end

    initial
    begin
        rst         = 1'b1;
        frame       = 1'b0;
        spawn       = '0;
        spawn_valid = 1'b0;
        cmd         = tetris_pkg::MOVE_LEFT;
        cmd_valid   = 1'b0;
        query_col   = '0;
        query_row   = '0;
        apply_reset();

        // Walk into the left wall, then random commands until it locks.
        run_piece(T_SHAPE, 6'd5, 6, 0, 1'b1);

        // Two flat bars at the walls and an upright bar on the left one.
        // The middle bar completes the bottom row.
        apply_reset();
        run_piece(H_BAR, 6'd9, 4, 0, 1'b0);
        run_piece(H_BAR, 6'd11, 0, 4, 1'b0);
        run_piece(V_BAR, 6'd12, 4, 0, 1'b0);
        run_piece(H_BAR, 6'd10, 0, 0, 1'b0);

        // Stack upright bars until the spawn is blocked.
        apply_reset();
        while (shape_fits(V_BAR, int'(tetris_pkg::SPAWN_COL), int'(tetris_pkg::SPAWN_ROW),
                          m_field))
            run_piece(V_BAR, 6'd20, 0, 0, 1'b0);
        spawn_piece(V_BAR, 6'd21);
        hold_after_over();

        $display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

// ==== src/tetris_core.sv ====
module tetris_core
(
    input  logic                Clk,
    input  logic                rst,
    input  logic                frame,
    input  tetris_pkg::spawn_t  spawn,
    input  logic                spawn_valid,
    output logic                spawn_ready,
    input  tetris_pkg::move_e   cmd,
    input  logic                cmd_valid,
    output logic                cmd_ready,
    input  tetris_pkg::col_t    query_col,
    input  tetris_pkg::row_t    query_row,
    output tetris_pkg::cell_e   query_cell,
    output tetris_pkg::piece_t  piece,
    output logic                piece_active,
    output tetris_pkg::field_t  field,
    output logic [15:0]         lines_cleared,
    output logic                game_over
);

    // Lock stream, payload is the stopped piece.
    logic lock_valid;
    logic lock_ready;

    falling_piece i_falling_piece (
        .Clk,
        .rst,
        .frame,
        .spawn,
        .spawn_valid,
        .spawn_ready,
        .cmd,
        .cmd_valid,
        .cmd_ready,
        .field,
        .piece,
        .piece_active,
        .lock_valid,
        .lock_ready,
        .game_over
    );

    settled_field i_settled_field (
        .Clk,
        .rst,
        .lock(piece),
        .lock_valid,
        .lock_ready,
        .field,
        .lines_cleared
    );

    cell_query i_cell_query (
        .piece,
        .piece_active,
        .field,
        .query_col,
        .query_row,
        .query_cell
    );

endmodule

// ==== src/cell_query.sv ====
module cell_query
(
    input  tetris_pkg::piece_t piece,
    input  logic               piece_active,
    input  tetris_pkg::field_t field,
    input  tetris_pkg::col_t   query_col,
    input  tetris_pkg::row_t   query_row,
    output tetris_pkg::cell_e  query_cell
);

    always_comb
    begin
        int   dr;
        int   dc;
        logic covers;

        // Offset of the cell inside the piece mask.
        dr = int'(query_row) - int'(piece.row);
        dc = int'(query_col) - int'($signed(piece.col));
        covers = 1'b0;
        if (dr >= 0 && dr < tetris_pkg::SHAPE_DIM && dc >= 0 && dc < tetris_pkg::SHAPE_DIM)
            covers = piece.shape[dr*tetris_pkg::SHAPE_DIM + dc];

        query_cell = tetris_pkg::CELL_EMPTY;
        if (piece_active && covers)
            query_cell = tetris_pkg::CELL_FALLING;
        else if (query_col >= 0 && int'(query_col) < tetris_pkg::GRID_COLS &&
                 int'(query_row) < tetris_pkg::GRID_ROWS)
        begin
            if (field[int'(query_row)*tetris_pkg::GRID_COLS + int'(query_col)])
                query_cell = tetris_pkg::CELL_SETTLED;
        end
    end

endmodule

// ==== src/settled_field.sv ====
module settled_field
(
    input  logic               Clk,
    input  logic               rst,
    input  tetris_pkg::piece_t lock,
    input  logic               lock_valid,
    output logic               lock_ready,
    output tetris_pkg::field_t field,
    output logic [15:0]        lines_cleared
);

    typedef enum logic {
        S_IDLE,
        S_SCAN
    } state_e;

    state_e             state;
    tetris_pkg::row_t   scan_row;
    tetris_pkg::field_t piece_mask;
    tetris_pkg::field_t field_shift;
    logic               row_full;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Cells covered by the locking piece.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb
    begin
        int gr;
        int gc;

        piece_mask = '0;
        for (int r = 0; r < tetris_pkg::SHAPE_DIM; r++)
        begin
            for (int c = 0; c < tetris_pkg::SHAPE_DIM; c++)
            begin
                gr = int'(lock.row) + r;
                gc = int'($signed(lock.col)) + c;
                if (lock.shape[r*tetris_pkg::SHAPE_DIM + c] && gc >= 0 &&
                    gc < tetris_pkg::GRID_COLS && gr < tetris_pkg::GRID_ROWS)
                begin
                    piece_mask[gr*tetris_pkg::GRID_COLS + gc] = 1'b1;
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Row scan and removal.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign row_full = &field[scan_row*tetris_pkg::GRID_COLS +: tetris_pkg::GRID_COLS];

    // Rows at and above the scan row move down by one.
    always_comb
    begin
        for (int k = 0; k < tetris_pkg::GRID_ROWS; k++)
        begin
            if (k > int'(scan_row))
                field_shift[k*tetris_pkg::GRID_COLS +: tetris_pkg::GRID_COLS] =
                    field[k*tetris_pkg::GRID_COLS +: tetris_pkg::GRID_COLS];
            else if (k == 0)
                field_shift[0 +: tetris_pkg::GRID_COLS] = '0;
            else
                field_shift[k*tetris_pkg::GRID_COLS +: tetris_pkg::GRID_COLS] =
                    field[(k-1)*tetris_pkg::GRID_COLS +: tetris_pkg::GRID_COLS];
        end
    end

    assign lock_ready = (state == S_IDLE);

    always_ff @(posedge Clk)
    begin
        if (rst)
        begin
            state         <= S_IDLE;
            scan_row      <= tetris_pkg::row_t'(tetris_pkg::GRID_ROWS - 1);
            field         <= '0;
            lines_cleared <= '0;
        end
        else if (state == S_IDLE)
        begin
            if (lock_valid)
            begin
                field    <= field | piece_mask;
                scan_row <= tetris_pkg::row_t'(tetris_pkg::GRID_ROWS - 1);
                state    <= S_SCAN;
            end
        end
        else if (row_full)
        begin
            // Same row again, it now holds the row from above.
            field         <= field_shift;
            lines_cleared <= lines_cleared + 16'd1;
        end
        else if (scan_row == '0)
        begin
            state <= S_IDLE;
        end
        else
        begin
            scan_row <= scan_row - 5'd1;
        end
    end

endmodule

// ==== src/falling_piece.sv ====
module falling_piece
(
    input  logic                Clk,
    input  logic                rst,
    input  logic                frame,
    input  tetris_pkg::spawn_t  spawn,
    input  logic                spawn_valid,
    output logic                spawn_ready,
    input  tetris_pkg::move_e   cmd,
    input  logic                cmd_valid,
    output logic                cmd_ready,
    input  tetris_pkg::field_t  field,
    output tetris_pkg::piece_t  piece,
    output logic                piece_active,
    output logic                lock_valid,
    input  logic                lock_ready,
    output logic                game_over
);

    typedef enum logic [1:0] {
        S_SPAWN,
        S_FALL,
        S_LOCK,
        S_OVER
    } state_e;

    state_e             state;
    logic               frame_q1;
    logic               frame_q2;
    logic               step;
    logic               move_step;
    logic               spawn_xfer;
    logic               cmd_xfer;
    tetris_pkg::shape_t shape_cw;
    tetris_pkg::shape_t shape_ccw;
    tetris_pkg::col_t   col_left;
    tetris_pkg::col_t   col_right;
    tetris_pkg::row_t   row_down;
    logic               fit_spawn;
    logic               fit_down;
    logic               fit_left;
    logic               fit_right;
    logic               fit_cw;
    logic               fit_ccw;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Candidate positions and their fit checks.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign col_left  = piece.col - 6'sd1;
    assign col_right = piece.col + 6'sd1;
    assign row_down  = piece.row + 5'd1;

    piece_rotate i_piece_rotate (.shape(piece.shape), .shape_cw, .shape_ccw);

    piece_fit i_fit_spawn (.shape(spawn.shape), .col(tetris_pkg::SPAWN_COL),
                           .row(tetris_pkg::SPAWN_ROW), .field, .fits(fit_spawn));
    piece_fit i_fit_down  (.shape(piece.shape), .col(piece.col), .row(row_down),
                           .field, .fits(fit_down));
    piece_fit i_fit_left  (.shape(piece.shape), .col(col_left), .row(piece.row),
                           .field, .fits(fit_left));
    piece_fit i_fit_right (.shape(piece.shape), .col(col_right), .row(piece.row),
                           .field, .fits(fit_right));
    piece_fit i_fit_cw    (.shape(shape_cw), .col(piece.col), .row(piece.row),
                           .field, .fits(fit_cw));
    piece_fit i_fit_ccw   (.shape(shape_ccw), .col(piece.col), .row(piece.row),
                           .field, .fits(fit_ccw));

    // Two sync stages, then a one-cycle step pulse.
    always_ff @(posedge Clk)
    begin
        if (rst)
        begin
            frame_q1 <= 1'b0;
            frame_q2 <= 1'b0;
            step     <= 1'b0;
        end
        else
        begin
            frame_q1 <= frame;
            frame_q2 <= frame_q1;
            step     <= frame_q1 && !frame_q2;
        end
    end

    // A piece that is about to lock takes no command; it waits.
    assign move_step    = step && (state == S_FALL) && fit_down;
    assign cmd_ready    = move_step;
    assign cmd_xfer     = cmd_valid && cmd_ready;
    assign spawn_ready  = (state == S_SPAWN) && lock_ready;
    assign spawn_xfer   = spawn_valid && spawn_ready;
    assign piece_active = (state == S_FALL) || (state == S_LOCK);
    assign lock_valid   = (state == S_LOCK);
    assign game_over    = (state == S_OVER);

    always_ff @(posedge Clk)
    begin
        if (rst)
        begin
            state <= S_SPAWN;
        end
        else
        begin
            case (state)
                S_SPAWN:
                    if (spawn_xfer)
                        state <= fit_spawn ? S_FALL : S_OVER;
                S_FALL:
                    if (step && !fit_down)
                        state <= S_LOCK;
                S_LOCK:
                    if (lock_ready)
                        state <= S_SPAWN;
                default:
                    state <= state;
            endcase
        end
    end

    // Piece position and shape. One action per step.
    always_ff @(posedge Clk)
    begin
        if (spawn_xfer)
        begin
            piece <= '{shape: spawn.shape, col: tetris_pkg::SPAWN_COL,
                       row: tetris_pkg::SPAWN_ROW, color: spawn.color};
        end
        else if (cmd_xfer)
        begin
            case (cmd)
                tetris_pkg::MOVE_LEFT:  if (fit_left)  piece.col   <= col_left;
                tetris_pkg::MOVE_RIGHT: if (fit_right) piece.col   <= col_right;
                tetris_pkg::ROT_CW:     if (fit_cw)    piece.shape <= shape_cw;
                default:                if (fit_ccw)   piece.shape <= shape_ccw;
            endcase
        end
        else if (move_step)
        begin
            piece.row <= row_down;
        end
    end

endmodule

// ==== src/piece_fit.sv ====
module piece_fit
(
    input  tetris_pkg::shape_t shape,
    input  tetris_pkg::col_t   col,
    input  tetris_pkg::row_t   row,
    input  tetris_pkg::field_t field,
    output logic               fits
);

    always_comb
    begin
        int gr;
        int gc;

        fits = 1'b1;
        for (int r = 0; r < tetris_pkg::SHAPE_DIM; r++)
        begin
            for (int c = 0; c < tetris_pkg::SHAPE_DIM; c++)
            begin
                gr = int'(row) + r;
                gc = int'(col) + c;
                if (shape[r*tetris_pkg::SHAPE_DIM + c])
                begin
                    // Outside the walls or the floor.
                    if (gc < 0 || gc >= tetris_pkg::GRID_COLS ||
                        gr >= tetris_pkg::GRID_ROWS)
                    begin
                        fits = 1'b0;
                    end
                    // On top of a settled cell.
                    else if (field[gr*tetris_pkg::GRID_COLS + gc])
                    begin
                        fits = 1'b0;
                    end
                end
            end
        end
    end

endmodule

// ==== src/piece_rotate.sv ====
module piece_rotate
(
    input  tetris_pkg::shape_t shape,
    output tetris_pkg::shape_t shape_cw,
    output tetris_pkg::shape_t shape_ccw
);

    always_comb
    begin
        for (int r = 0; r < tetris_pkg::SHAPE_DIM; r++)
        begin
            for (int c = 0; c < tetris_pkg::SHAPE_DIM; c++)
            begin
                // New (r,c) takes old (3-c, r).
                shape_cw[r*tetris_pkg::SHAPE_DIM + c] =
                    shape[(tetris_pkg::SHAPE_DIM-1-c)*tetris_pkg::SHAPE_DIM + r];

                // New (r,c) takes old (c, 3-r).
                shape_ccw[r*tetris_pkg::SHAPE_DIM + c] =
                    shape[c*tetris_pkg::SHAPE_DIM + (tetris_pkg::SHAPE_DIM-1-r)];
            end
        end
    end

endmodule

// ==== src/tetris_pkg.sv ====
package tetris_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Grid geometry.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int GRID_COLS  = 12;
    localparam int GRID_ROWS  = 20;
    localparam int SHAPE_DIM  = 4;
    localparam int FIELD_BITS = GRID_COLS * GRID_ROWS;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Value types.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Bit r*4+c is shape row r, shape column c; row 0 on top.
    typedef logic [SHAPE_DIM*SHAPE_DIM-1:0] shape_t;

    // Signed, since a mask may have empty left columns.
    typedef logic signed [5:0] col_t;
    typedef logic [4:0]        row_t;
    typedef logic [5:0]        color_t;

    // Bit row*12+col, row 0 on top.
    typedef logic [FIELD_BITS-1:0] field_t;

    // Where a new piece enters.
    localparam col_t SPAWN_COL = 6'sd4;
    localparam row_t SPAWN_ROW = 5'd0;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Structs and enums.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        shape_t shape;
        col_t   col;
        row_t   row;
        color_t color;
    } piece_t;

    typedef struct packed {
        shape_t shape;
        color_t color;
    } spawn_t;

    typedef enum logic [1:0] {
        MOVE_LEFT  = 2'd0,
        MOVE_RIGHT = 2'd1,
        ROT_CW     = 2'd2,
        ROT_CCW    = 2'd3
    } move_e;

    typedef enum logic [1:0] {
        CELL_EMPTY   = 2'd0,
        CELL_FALLING = 2'd1,
        CELL_SETTLED = 2'd2
    } cell_e;

endpackage
